/* board_ctrl.sv */
`timescale 1ns/100ps

module board_ctrl (
    input  logic                         clk27,
    input  logic                         sys_reset_n,
    input  logic [pro_pkg::CTRL_W-1:0]   sys_ctrl_i,
    input  logic [pro_pkg::BTN_W-1:0]    btn_i,
    // audio from the hdmi receiver
    input  logic                         hdmirx_i2s_bck_i,
    input  logic                         hdmirx_i2s_ws_i,
    input  logic                         hdmirx_ap_i,
    // audio from the pcm adc
    input  logic                         pcm_i2s_bck_i,
    input  logic                         pcm_i2s_ws_i,
    input  logic                         pcm_i2s_data_i,
    input  logic                         spdif_ext_i,
    output logic                         capture_sel_o,
    output logic                         isl_reset_n_o,
    output logic                         hdmirx_reset_n_o,
    output logic                         audmux_o,
    output logic                         tx_i2s_bck_o,
    output logic                         tx_i2s_ws_o,
    output logic                         tx_i2s_data_o,
    output logic                         tx_spdif_o,
    output logic [pro_pkg::STATUS_W-1:0] sys_status_o
);

    logic                      capture_sel;
    // button synchronizer stages
    logic [pro_pkg::BTN_W-1:0] btn_sync1_q;
    logic [pro_pkg::BTN_W-1:0] btn_sync2_q;

    // control word decode
    assign capture_sel      = sys_ctrl_i[pro_pkg::CTRL_CAPTURE_SEL_BIT];
    assign capture_sel_o    = capture_sel;
    assign isl_reset_n_o    = sys_ctrl_i[pro_pkg::CTRL_ISL_RESET_N_BIT];
    assign hdmirx_reset_n_o = sys_ctrl_i[pro_pkg::CTRL_HDMIRX_RESET_N_BIT];
    // external audio mux select pin is active low
    assign audmux_o         = ~sys_ctrl_i[pro_pkg::CTRL_AUDMUX_SEL_BIT];

    // i2s follows the video source
    // receiver audio port carries the serial data
    assign tx_i2s_bck_o  = capture_sel ? hdmirx_i2s_bck_i : pcm_i2s_bck_i;
    assign tx_i2s_ws_o   = capture_sel ? hdmirx_i2s_ws_i : pcm_i2s_ws_i;
    assign tx_i2s_data_o = capture_sel ? hdmirx_ap_i : pcm_i2s_data_i;

    // s/pdif bypasses the mux
    assign tx_spdif_o = spdif_ext_i;

    // buttons are active low, idle reads as ones
    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            btn_sync1_q <= '1;
            btn_sync2_q <= '1;
        end else begin
            btn_sync1_q <= btn_i;
            btn_sync2_q <= btn_sync1_q;
        end
    end

    // status word, upper bits reserved
    assign sys_status_o = {{(pro_pkg::STATUS_W - pro_pkg::BTN_W){1'b0}}, btn_sync2_q};

endmodule

/* capture_select.sv */
`timescale 1ns/100ps

module capture_select (
    input  logic                        clk27,
    input  logic                        sys_reset_n,
    video_if.snk                        isl_i,
    video_if.snk                        hdmi_i,
    input  logic                        capture_sel_i,
    output logic [pro_pkg::COLOR_W-1:0] tx_r_o,
    output logic [pro_pkg::COLOR_W-1:0] tx_g_o,
    output logic [pro_pkg::COLOR_W-1:0] tx_b_o,
    output logic                        tx_hsync_o,
    output logic                        tx_vsync_o,
    output logic                        tx_de_o
);

    // r, g, b, hsync, vsync, de packed msb first
    localparam int WORD_W = 3 * pro_pkg::COLOR_W + 3;

    logic [WORD_W-1:0] isl_word;
    logic [WORD_W-1:0] hdmi_word;
    // selected source
    logic [WORD_W-1:0] capt_q;
    // transmitter pin register
    logic [WORD_W-1:0] tx_q;

    assign isl_word = {isl_i.r, isl_i.g, isl_i.b, isl_i.hsync, isl_i.vsync, isl_i.de};
    assign hdmi_word = {hdmi_i.r, hdmi_i.g, hdmi_i.b, hdmi_i.hsync, hdmi_i.vsync, hdmi_i.de};

    // capture mux, select is a quasi-static host setting
    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            capt_q <= '0;
        end else begin
            capt_q <= capture_sel_i ? hdmi_word : isl_word;
        end
    end

    // output stage toward the hdmi transmitter
    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            tx_q <= '0;
        end else begin
            tx_q <= capt_q;
        end
    end

    assign {tx_r_o, tx_g_o, tx_b_o, tx_hsync_o, tx_vsync_o, tx_de_o} = tx_q;

    // an undriven source input would show up here first
    a_tx_de_known: assert property (
        @(posedge clk27) disable iff (!sys_reset_n)
        !$isunknown(tx_de_o)
    );

endmodule

/* ossc_top.sv */
`timescale 1ns/100ps

module ossc_top #(
    parameter int RESET_CYCLES     = pro_pkg::PO_RESET_WIDTH,
    parameter int ISL_SYNC_STAGES  = 2,
    parameter int HDMI_SYNC_STAGES = 1,
    parameter int LED_HOLD_W       = pro_pkg::LED_HOLD_W_DEFAULT
) (
    input  logic                         clk27,
    input  logic                         po_reset_n,
    // analog digitizer
    input  logic [pro_pkg::COLOR_W-1:0]  isl_r_i,
    input  logic [pro_pkg::COLOR_W-1:0]  isl_g_i,
    input  logic [pro_pkg::COLOR_W-1:0]  isl_b_i,
    input  logic                         isl_hsync_i,
    input  logic                         isl_vsync_i,
    input  logic                         isl_de_i,
    output logic                         isl_reset_n_o,
    // hdmi receiver
    input  logic [pro_pkg::COLOR_W-1:0]  hdmirx_r_i,
    input  logic [pro_pkg::COLOR_W-1:0]  hdmirx_g_i,
    input  logic [pro_pkg::COLOR_W-1:0]  hdmirx_b_i,
    input  logic                         hdmirx_hsync_i,
    input  logic                         hdmirx_vsync_i,
    input  logic                         hdmirx_de_i,
    input  logic                         hdmirx_i2s_bck_i,
    input  logic                         hdmirx_i2s_ws_i,
    input  logic                         hdmirx_ap_i,
    output logic                         hdmirx_reset_n_o,
    // hdmi transmitter
    output logic [pro_pkg::COLOR_W-1:0]  tx_r_o,
    output logic [pro_pkg::COLOR_W-1:0]  tx_g_o,
    output logic [pro_pkg::COLOR_W-1:0]  tx_b_o,
    output logic                         tx_hsync_o,
    output logic                         tx_vsync_o,
    output logic                         tx_de_o,
    output logic                         tx_i2s_bck_o,
    output logic                         tx_i2s_ws_o,
    output logic                         tx_i2s_data_o,
    output logic                         tx_spdif_o,
    // audio sources and mux
    input  logic                         pcm_i2s_bck_i,
    input  logic                         pcm_i2s_ws_i,
    input  logic                         pcm_i2s_data_i,
    input  logic                         spdif_ext_i,
    output logic                         audmux_o,
    // host side and panel
    input  logic [pro_pkg::CTRL_W-1:0]   sys_ctrl_i,
    output logic [pro_pkg::STATUS_W-1:0] sys_status_o,
    input  logic [pro_pkg::BTN_W-1:0]    btn_i,
    input  logic                         resync_strobe_i,
    output logic                         led_o,
    output logic                         sys_reset_n_o
);

    // capture source select from the control word
    logic capture_sel;

    // registered streams into the capture mux
    video_if isl_vid ();
    video_if hdmi_vid ();

    // system reset, also used internally
    sys_rst_gen #(
        .RESET_CYCLES (RESET_CYCLES)
    ) u_sys_rst_gen (
        .clk27         (clk27),
        .po_reset_n    (po_reset_n),
        .sys_reset_n_o (sys_reset_n_o)
    );

    // digitizer syncs get an extra stage
    video_in_reg #(
        .SYNC_STAGES (ISL_SYNC_STAGES)
    ) u_isl_in (
        .clk27       (clk27),
        .sys_reset_n (sys_reset_n_o),
        .r_i         (isl_r_i),
        .g_i         (isl_g_i),
        .b_i         (isl_b_i),
        .hsync_i     (isl_hsync_i),
        .vsync_i     (isl_vsync_i),
        .de_i        (isl_de_i),
        .vid_o       (isl_vid.src)
    );

    video_in_reg #(
        .SYNC_STAGES (HDMI_SYNC_STAGES)
    ) u_hdmi_in (
        .clk27       (clk27),
        .sys_reset_n (sys_reset_n_o),
        .r_i         (hdmirx_r_i),
        .g_i         (hdmirx_g_i),
        .b_i         (hdmirx_b_i),
        .hsync_i     (hdmirx_hsync_i),
        .vsync_i     (hdmirx_vsync_i),
        .de_i        (hdmirx_de_i),
        .vid_o       (hdmi_vid.src)
    );

    capture_select u_capture_select (
        .clk27         (clk27),
        .sys_reset_n   (sys_reset_n_o),
        .isl_i         (isl_vid.snk),
        .hdmi_i        (hdmi_vid.snk),
        .capture_sel_i (capture_sel),
        .tx_r_o        (tx_r_o),
        .tx_g_o        (tx_g_o),
        .tx_b_o        (tx_b_o),
        .tx_hsync_o    (tx_hsync_o),
        .tx_vsync_o    (tx_vsync_o),
        .tx_de_o       (tx_de_o)
    );

    resync_led #(
        .LED_HOLD_W (LED_HOLD_W)
    ) u_resync_led (
        .clk27           (clk27),
        .sys_reset_n     (sys_reset_n_o),
        .resync_strobe_i (resync_strobe_i),
        .led_o           (led_o)
    );

    board_ctrl u_board_ctrl (
        .clk27            (clk27),
        .sys_reset_n      (sys_reset_n_o),
        .sys_ctrl_i       (sys_ctrl_i),
        .btn_i            (btn_i),
        .hdmirx_i2s_bck_i (hdmirx_i2s_bck_i),
        .hdmirx_i2s_ws_i  (hdmirx_i2s_ws_i),
        .hdmirx_ap_i      (hdmirx_ap_i),
        .pcm_i2s_bck_i    (pcm_i2s_bck_i),
        .pcm_i2s_ws_i     (pcm_i2s_ws_i),
        .pcm_i2s_data_i   (pcm_i2s_data_i),
        .spdif_ext_i      (spdif_ext_i),
        .capture_sel_o    (capture_sel),
        .isl_reset_n_o    (isl_reset_n_o),
        .hdmirx_reset_n_o (hdmirx_reset_n_o),
        .audmux_o         (audmux_o),
        .tx_i2s_bck_o     (tx_i2s_bck_o),
        .tx_i2s_ws_o      (tx_i2s_ws_o),
        .tx_i2s_data_o    (tx_i2s_data_o),
        .tx_spdif_o       (tx_spdif_o),
        .sys_status_o     (sys_status_o)
    );

endmodule

/* pro_pkg.sv */
package pro_pkg;

    // video datapath widths
    // one color channel of the digitizer and receiver buses
    localparam int COLOR_W = 8;

    // host interface widths
    // control word written by the host
    localparam int CTRL_W = 16;
    // status word read back by the host
    localparam int STATUS_W = 32;
    // front panel buttons
    localparam int BTN_W = 2;

    // reset generation
    // clk27 cycles between power-on release and system release
    localparam int PO_RESET_WIDTH = 27;
    // reset counter width, must hold PO_RESET_WIDTH
    localparam int RST_CNT_W = 8;

    // control word bit map
    // bit 0 is a spare, bits 3 and 4 used to drive the memory resets
    localparam int CTRL_ISL_RESET_N_BIT = 1;
    localparam int CTRL_HDMIRX_RESET_N_BIT = 2;
    // 1 selects the hdmi receiver, 0 the analog digitizer
    localparam int CTRL_CAPTURE_SEL_BIT = 5;
    // bits 6 and 7 were vsync options of the digitizer frontend
    localparam int CTRL_AUDMUX_SEL_BIT = 8;

    // resync led
    // 24 bits gives roughly 0.6 s at 27 MHz
    localparam int LED_HOLD_W_DEFAULT = 24;

endpackage

/* resync_led.sv */
`timescale 1ns/100ps

module resync_led #(
    parameter int LED_HOLD_W = pro_pkg::LED_HOLD_W_DEFAULT
) (
    input  logic clk27,
    input  logic sys_reset_n,
    input  logic resync_strobe_i,
    output logic led_o
);

    // two-flop synchronizer and edge history
    logic strobe_sync1_q;
    logic strobe_sync2_q;
    logic strobe_prev_q;
    logic strobe_rise;
    // led on-time counter
    logic [LED_HOLD_W-1:0] hold_cnt;

    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            strobe_sync1_q <= 1'b0;
            strobe_sync2_q <= 1'b0;
            strobe_prev_q  <= 1'b0;
        end else begin
            strobe_sync1_q <= resync_strobe_i;
            strobe_sync2_q <= strobe_sync1_q;
            strobe_prev_q  <= strobe_sync2_q;
        end
    end

    // a level held high only fires once
    assign strobe_rise = strobe_sync2_q & ~strobe_prev_q;

    // reload on every new resync, else drain to zero
    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            hold_cnt <= '0;
        end else if (strobe_rise) begin
            hold_cnt <= '1;
        end else if (hold_cnt != '0) begin
            hold_cnt <= hold_cnt - 1'b1;
        end
    end

    assign led_o = (hold_cnt != '0);

    // idle counter stays idle until the next strobe rise
    a_no_wrap: assert property (
        @(posedge clk27) disable iff (!sys_reset_n)
        (hold_cnt == '0) && !strobe_rise |=> (hold_cnt == '0)
    );

endmodule

/* run_sim.sh */
#!/bin/sh
# compile and run the testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=tb_ossc_sim

# build
verilator --binary --timing --assert -Wno-fatal \
    -f src.f --top-module tb_ossc -Mdir obj_dir -o "$BIN"
if [ $? -ne 0 ]; then
    echo "compile step failed"
    exit 1
fi

# run, keeping the log for the pass search
./obj_dir/"$BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

# result is decided by the log only
if grep -q "^NO ERRORS$" "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

/* src.f */
pro_pkg.sv
video_if.sv
sys_rst_gen.sv
video_in_reg.sv
capture_select.sv
resync_led.sv
board_ctrl.sv
ossc_top.sv
tb_ossc.sv

/* sys_rst_gen.sv */
`timescale 1ns/100ps

module sys_rst_gen #(
    parameter int RESET_CYCLES = pro_pkg::PO_RESET_WIDTH
) (
    input  logic clk27,
    input  logic po_reset_n,
    output logic sys_reset_n_o
);

    // terminal count and the count seen on the release edge
    localparam logic [pro_pkg::RST_CNT_W-1:0] LAST_CNT = RESET_CYCLES[pro_pkg::RST_CNT_W-1:0];
    localparam logic [pro_pkg::RST_CNT_W-1:0] REL_CNT = LAST_CNT - 1'b1;

    logic [pro_pkg::RST_CNT_W-1:0] rst_cnt;

    // counts edges after power-on release, then parks
    always_ff @(posedge clk27 or negedge po_reset_n) begin
        if (!po_reset_n) begin
            rst_cnt <= '0;
        end else if (rst_cnt != LAST_CNT) begin
            rst_cnt <= rst_cnt + 1'b1;
        end
    end

    // release on the RESET_CYCLES-th edge, only po reset pulls it low again
    always_ff @(posedge clk27 or negedge po_reset_n) begin
        if (!po_reset_n) begin
            sys_reset_n_o <= 1'b0;
        end else if (rst_cnt == REL_CNT) begin
            sys_reset_n_o <= 1'b1;
        end
    end

    // the system never drops back into reset on its own
    a_release_sticky: assert property (
        @(posedge clk27) disable iff (!po_reset_n)
        sys_reset_n_o |=> sys_reset_n_o
    );

endmodule

/* tb_ossc.sv */
`timescale 1ns/100ps

module tb_ossc;

    localparam int CLK_PERIOD   = 20;
    localparam int RST_CYC      = pro_pkg::PO_RESET_WIDTH;
    localparam int LED_W        = 6;
    localparam int LED_HOLD_CYC = (1 << LED_W) - 1;
    // po_reset_n goes high in this cycle, sys reset follows RST_CYC edges later
    localparam int PO_REL_CYCLE = 2;
    localparam int REL_CYCLE    = PO_REL_CYCLE + RST_CYC;
    // test phases, in clock cycles
    localparam int HDMI_START   = RST_CYC + 12;
    localparam int ISL_START    = HDMI_START + 200;
    localparam int MIX_START    = ISL_START + 200;
    localparam int LED_START    = MIX_START + 150;
    localparam int TOTAL_CYCLES = LED_START + 560;
    localparam int HIST_LEN     = TOTAL_CYCLES + 8;
    localparam int WATCHDOG_NS  = (TOTAL_CYCLES + 100) * CLK_PERIOD;

    typedef struct packed {
        logic [pro_pkg::COLOR_W-1:0] r;
        logic [pro_pkg::COLOR_W-1:0] g;
        logic [pro_pkg::COLOR_W-1:0] b;
        logic hsync;
        logic vsync;
        logic de;
    } video_t;

    // everything driven into the DUT in one cycle
    typedef struct packed {
        video_t isl;
        video_t hdmi;
        logic hdmi_bck;
        logic hdmi_ws;
        logic hdmi_ap;
        logic pcm_bck;
        logic pcm_ws;
        logic pcm_data;
        logic spdif;
        logic [pro_pkg::BTN_W-1:0] btn;
        logic [pro_pkg::CTRL_W-1:0] ctrl;
        logic strobe;
    } stim_t;

    // DUT outputs as seen at the falling edge
    typedef struct packed {
        video_t tx;
        logic i2s_bck;
        logic i2s_ws;
        logic i2s_data;
        logic spdif;
        logic audmux;
        logic isl_rst_n;
        logic hdmirx_rst_n;
        logic [pro_pkg::STATUS_W-1:0] status;
        logic led;
        logic sys_rst_n;
    } pins_t;

    localparam int STIM_W = $bits(stim_t);

    logic   clk27;
    logic   po_reset_n;
    stim_t  drv;
    stim_t  hist [0:HIST_LEN-1];
    int     cyc = 0;
    int     err_cnt = 0;
    integer seed;
    pins_t  got;

    ossc_top #(
        .RESET_CYCLES (RST_CYC),
        .LED_HOLD_W   (LED_W)
    ) i_dut (
        .clk27            (clk27),
        .po_reset_n       (po_reset_n),
        .isl_r_i          (drv.isl.r),
        .isl_g_i          (drv.isl.g),
        .isl_b_i          (drv.isl.b),
        .isl_hsync_i      (drv.isl.hsync),
        .isl_vsync_i      (drv.isl.vsync),
        .isl_de_i         (drv.isl.de),
        .isl_reset_n_o    (got.isl_rst_n),
        .hdmirx_r_i       (drv.hdmi.r),
        .hdmirx_g_i       (drv.hdmi.g),
        .hdmirx_b_i       (drv.hdmi.b),
        .hdmirx_hsync_i   (drv.hdmi.hsync),
        .hdmirx_vsync_i   (drv.hdmi.vsync),
        .hdmirx_de_i      (drv.hdmi.de),
        .hdmirx_i2s_bck_i (drv.hdmi_bck),
        .hdmirx_i2s_ws_i  (drv.hdmi_ws),
        .hdmirx_ap_i      (drv.hdmi_ap),
        .hdmirx_reset_n_o (got.hdmirx_rst_n),
        .tx_r_o           (got.tx.r),
        .tx_g_o           (got.tx.g),
        .tx_b_o           (got.tx.b),
        .tx_hsync_o       (got.tx.hsync),
        .tx_vsync_o       (got.tx.vsync),
        .tx_de_o          (got.tx.de),
        .tx_i2s_bck_o     (got.i2s_bck),
        .tx_i2s_ws_o      (got.i2s_ws),
        .tx_i2s_data_o    (got.i2s_data),
        .tx_spdif_o       (got.spdif),
        .pcm_i2s_bck_i    (drv.pcm_bck),
        .pcm_i2s_ws_i     (drv.pcm_ws),
        .pcm_i2s_data_i   (drv.pcm_data),
        .spdif_ext_i      (drv.spdif),
        .audmux_o         (got.audmux),
        .sys_ctrl_i       (drv.ctrl),
        .sys_status_o     (got.status),
        .btn_i            (drv.btn),
        .resync_strobe_i  (drv.strobe),
        .led_o            (got.led),
        .sys_reset_n_o    (got.sys_rst_n)
    );

    initial begin
        clk27 = 1'b0;
        forever #(CLK_PERIOD / 2) clk27 = ~clk27;
    end

    // system reset is out of reset from the falling edge of cycle m on
    function automatic bit is_up(input int m);
        return m >= REL_CYCLE;
    endfunction

    // single pulses, a two cycle pulse, a retrigger pair and a long held level
    function automatic bit strobe_pattern(input int k);
        return (k == 5) || (k >= 100 && k < 102) || (k == 200) || (k == 230) ||
               (k >= 320 && k < 470);
    endfunction

    function automatic stim_t next_stim(input int n);
        stim_t s;
        logic [95:0] rbits;
        rbits = {$random(seed), $random(seed), $random(seed)};
        s = rbits[STIM_W-1:0];
        s.strobe = (n >= LED_START) ? strobe_pattern(n - LED_START) : 1'b0;
        // fixed source per phase, mixed phase keeps the random select
        if (n >= HDMI_START && n < ISL_START) begin
            s.ctrl[pro_pkg::CTRL_CAPTURE_SEL_BIT] = 1'b1;
        end else if (n >= ISL_START && n < MIX_START) begin
            s.ctrl[pro_pkg::CTRL_CAPTURE_SEL_BIT] = 1'b0;
        end
        return s;
    endfunction

    // expected pins in cycle n from the input history
    function automatic pins_t expected_pins(input int n);
        pins_t e;
        stim_t cur;
        bit    sel;
        int    j;
        e = '0;
        cur = hist[n];
        // decode and audio routing have no latency
        sel = cur.ctrl[pro_pkg::CTRL_CAPTURE_SEL_BIT];
        e.isl_rst_n    = cur.ctrl[pro_pkg::CTRL_ISL_RESET_N_BIT];
        e.hdmirx_rst_n = cur.ctrl[pro_pkg::CTRL_HDMIRX_RESET_N_BIT];
        e.audmux       = ~cur.ctrl[pro_pkg::CTRL_AUDMUX_SEL_BIT];
        e.i2s_bck      = sel ? cur.hdmi_bck : cur.pcm_bck;
        e.i2s_ws       = sel ? cur.hdmi_ws : cur.pcm_ws;
        e.i2s_data     = sel ? cur.hdmi_ap : cur.pcm_data;
        e.spdif        = cur.spdif;
        e.sys_rst_n    = is_up(n);
        // 3 cycles for video, select taken one cycle before the output register
        if (is_up(n - 3)) begin
            if (hist[n-2].ctrl[pro_pkg::CTRL_CAPTURE_SEL_BIT]) begin
                e.tx = hist[n-3].hdmi;
            end else begin
                e.tx = hist[n-3].isl;
                // digitizer syncs take one extra stage
                e.tx.hsync = is_up(n - 4) ? hist[n-4].isl.hsync : 1'b0;
                e.tx.vsync = is_up(n - 4) ? hist[n-4].isl.vsync : 1'b0;
            end
        end
        // buttons idle as ones while in reset
        e.status[pro_pkg::BTN_W-1:0] = is_up(n - 2) ? hist[n-2].btn : '1;
        // led lit from 3 cycles after a rise, for LED_HOLD_CYC cycles
        for (j = n - 3; j >= n - LED_HOLD_CYC - 2; j--) begin
            if (j >= 1 && is_up(j) && hist[j].strobe && !hist[j-1].strobe) begin
                e.led = 1'b1;
            end
        end
        return e;
    endfunction

    task automatic check_value(input string what, input logic [31:0] act,
                               input logic [31:0] exp);
        if (act !== exp) begin
            err_cnt++;
            $display("Error at time %0t: %s is 0x%0h, expected 0x%0h (cycle %0d)",
                     $time, what, act, exp, cyc);
            $display("ERRORS FOUND");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic compare_pins(input int n);
        pins_t e;
        e = expected_pins(n);
        check_value("sys_reset_n_o", 32'(got.sys_rst_n), 32'(e.sys_rst_n));
        check_value("tx_r_o", 32'(got.tx.r), 32'(e.tx.r));
        check_value("tx_g_o", 32'(got.tx.g), 32'(e.tx.g));
        check_value("tx_b_o", 32'(got.tx.b), 32'(e.tx.b));
        check_value("tx_hsync_o", 32'(got.tx.hsync), 32'(e.tx.hsync));
        check_value("tx_vsync_o", 32'(got.tx.vsync), 32'(e.tx.vsync));
        check_value("tx_de_o", 32'(got.tx.de), 32'(e.tx.de));
        check_value("isl_reset_n_o", 32'(got.isl_rst_n), 32'(e.isl_rst_n));
        check_value("hdmirx_reset_n_o", 32'(got.hdmirx_rst_n), 32'(e.hdmirx_rst_n));
        check_value("audmux_o", 32'(got.audmux), 32'(e.audmux));
        check_value("tx_i2s_bck_o", 32'(got.i2s_bck), 32'(e.i2s_bck));
        check_value("tx_i2s_ws_o", 32'(got.i2s_ws), 32'(e.i2s_ws));
        check_value("tx_i2s_data_o", 32'(got.i2s_data), 32'(e.i2s_data));
        check_value("tx_spdif_o", 32'(got.spdif), 32'(e.spdif));
        check_value("sys_status_o", got.status, e.status);
        check_value("led_o", 32'(got.led), 32'(e.led));
    endtask

    // outputs are settled at the falling edge
    always @(negedge clk27) begin
        if (cyc > 0) begin
            compare_pins(cyc);
        end
    end

    initial begin : stimulus
        int k;
        seed = 61;
        po_reset_n = 1'b0;
        drv = '0;
        hist[0] = '0;
        for (k = 0; k < TOTAL_CYCLES; k++) begin
            @(posedge clk27);
            #2;
            cyc = cyc + 1;
            if (cyc == PO_REL_CYCLE) begin
                po_reset_n = 1'b1;
            end
            drv = next_stim(cyc);
            hist[cyc] = drv;
        end
        // let the last cycle be compared
        @(negedge clk27);
        #1;
        if (err_cnt == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            $display("ERRORS FOUND");
            $fatal(1, "mismatches were found");
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Timeout: the test did not finish within %0d ns", WATCHDOG_NS);
        $display("ERRORS FOUND");
        $fatal(1, "watchdog expired");
    end

endmodule

/* video_if.sv */
`timescale 1ns/100ps

interface video_if;

    // pixel data, one word per channel
    logic [pro_pkg::COLOR_W-1:0] r;
    logic [pro_pkg::COLOR_W-1:0] g;
    logic [pro_pkg::COLOR_W-1:0] b;

    // sync and data enable, active high as seen by the capture mux
    logic hsync;
    logic vsync;
    logic de;

    // input register stage drives the stream
    modport src (
        output r, g, b,
        output hsync, vsync, de
    );

    // capture mux reads it
    modport snk (
        input r, g, b,
        input hsync, vsync, de
    );

endinterface

/* video_in_reg.sv */
`timescale 1ns/100ps

module video_in_reg #(
    parameter int SYNC_STAGES = 1
) (
    input  logic                        clk27,
    input  logic                        sys_reset_n,
    input  logic [pro_pkg::COLOR_W-1:0] r_i,
    input  logic [pro_pkg::COLOR_W-1:0] g_i,
    input  logic [pro_pkg::COLOR_W-1:0] b_i,
    input  logic                        hsync_i,
    input  logic                        vsync_i,
    input  logic                        de_i,
    video_if.src                        vid_o
);

    // sync flop chains, stage 0 samples the pin
    logic [SYNC_STAGES-1:0] hs_pipe;
    logic [SYNC_STAGES-1:0] vs_pipe;

    // pixel data and de, single register
    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            vid_o.r  <= '0;
            vid_o.g  <= '0;
            vid_o.b  <= '0;
            vid_o.de <= 1'b0;
        end else begin
            vid_o.r  <= r_i;
            vid_o.g  <= g_i;
            vid_o.b  <= b_i;
            vid_o.de <= de_i;
        end
    end

    // syncs may come from a slower path, so extra stages are allowed
    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            hs_pipe <= '0;
            vs_pipe <= '0;
        end else begin
            hs_pipe[0] <= hsync_i;
            vs_pipe[0] <= vsync_i;
            for (int i = 1; i < SYNC_STAGES; i++) begin
                hs_pipe[i] <= hs_pipe[i-1];
                vs_pipe[i] <= vs_pipe[i-1];
            end
        end
    end

    // last stage drives the stream
    assign vid_o.hsync = hs_pipe[SYNC_STAGES-1];
    assign vid_o.vsync = vs_pipe[SYNC_STAGES-1];

endmodule
